// File: design/nmr_seq_pkg.sv
// sequence timing widths and phase encoding, imported by the pulse programmer top and sequencer
`default_nettype none

package nmr_seq_pkg;

	// ======================================================================
	// widths
	// ======================================================================

	localparam int PULSE_DELAY_WIDTH = 32;	// pulse and delay lengths in clock cycles
	localparam int COUNT_WIDTH       = 16;	// samples per echo, echoes per scan

	// ======================================================================
	// types
	// ======================================================================

	// length of one phase, in pulseprog_clk cycles
	typedef logic [PULSE_DELAY_WIDTH-1:0] seq_time_t;

	// sample or echo count
	typedef logic [COUNT_WIDTH-1:0] seq_count_t;

	// sequencer phases, in the order a CPMG scan walks them
	typedef enum logic [2:0] {
		ST_IDLE       = 3'd0,	// waiting for start
		ST_PULSE_90   = 3'd1,	// excitation pulse
		ST_DELAY_90   = 3'd2,	// wait before the first refocusing pulse
		ST_PULSE_180  = 3'd3,	// refocusing pulse, once per echo
		ST_DELAY_ECHO = 3'd4,	// dead time before the window
		ST_ACQUIRE    = 3'd5	// receiver open, adc window
	} seq_state_t;

endpackage

`default_nettype wire

// File: design/nmr_data_pkg.sv
// adc sample, i/q and buffer entry types, imported by every block of the receive data path
`default_nettype none

package nmr_data_pkg;

	// ======================================================================
	// adc side
	// ======================================================================

	localparam int ADC_PHYS_WIDTH = 14;	// magnitude bits, over-range bit not counted

	// raw adc bus, over-range flag on the msb
	typedef logic [ADC_PHYS_WIDTH:0] adc_word_t;

	// one signed i or q value, one bit wider than the magnitude
	typedef logic signed [ADC_PHYS_WIDTH:0] iq_val_t;

	// ======================================================================
	// buffer and output side
	// ======================================================================

	// buffer entry
	typedef struct packed {
		logic    first;	// first capture of a scan
		iq_val_t i;
		iq_val_t q;
	} iq_entry_t;

	// output word, i in the upper half
	typedef struct packed {
		logic signed [15:0] i;
		logic signed [15:0] q;
	} iq_out_t;

	localparam int DEC_WIDTH = 16;	// decimation factor width

endpackage

`default_nettype wire

// File: design/cpmg_sequencer.sv
// cpmg phase sequencer, times the pulses, delays and acquisition windows of one scan per start
`timescale 1ns/100ps
`default_nettype none

module cpmg_sequencer (
	input  wire                     pulseprog_clk,
	input  wire                     arst_n,
	input  wire                     start,
	input  wire                     phase_cycle,		// first rf level of the 90 pulse
	input  wire nmr_seq_pkg::seq_time_t  pulse_90,
	input  wire nmr_seq_pkg::seq_time_t  pulse_180,
	input  wire nmr_seq_pkg::seq_time_t  delay_nosig,
	input  wire nmr_seq_pkg::seq_count_t samples_per_echo,
	input  wire nmr_seq_pkg::seq_count_t echoes_per_scan,
	input  wire                     tx_en,
	input  wire                     tx_sd_mask,
	output logic                    busy,
	output logic                    scan_start,
	output logic                    acq_window,
	output logic                    rf_out_p,
	output logic                    rf_out_n,
	output logic                    tx_out
);
	import nmr_seq_pkg::*;

	seq_state_t state;
	seq_time_t  timer;		// cycles left in this phase, minus one
	seq_count_t echo_left;	// echoes still to run after the current one
	seq_time_t  pulse_180_r;
	seq_time_t  delay_r;
	seq_count_t samples_r;
	logic       rf_phase;	// rf_out_p level while in a pulse
	logic       in_pulse;
	logic       phase_end;	// last cycle of the current phase
	logic       accept;		// start taken this cycle

	// a zero length runs as a single cycle
	function automatic seq_time_t last_tick(input seq_time_t len);
		return (len == '0) ? '0 : len - seq_time_t'(1);
	endfunction

	assign accept    = (state == ST_IDLE) & start;
	assign phase_end = (timer == '0);
	assign in_pulse  = (state == ST_PULSE_90) | (state == ST_PULSE_180);

	// ======================================================================
	// parameter capture
	// ======================================================================

	// held for the whole scan, host may change inputs while busy
	always_ff @(posedge pulseprog_clk)
	begin
		if (accept)
		begin
			pulse_180_r <= pulse_180;
			delay_r     <= delay_nosig;
			samples_r   <= samples_per_echo;
		end
	end

	// ======================================================================
	// phase fsm
	// ======================================================================

	always_ff @(posedge pulseprog_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state      <= ST_IDLE;
			timer      <= '0;
			echo_left  <= '0;
			rf_phase   <= 1'b0;
			scan_start <= 1'b0;
		end
		else
		begin
			scan_start <= accept;	// one cycle, lines up with first busy cycle
			if (!phase_end)
			begin
				timer <= timer - seq_time_t'(1);
				if (in_pulse)
					rf_phase <= ~rf_phase;	// carrier toggle every cycle
			end
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						state     <= ST_PULSE_90;
						timer     <= last_tick(pulse_90);
						rf_phase  <= phase_cycle;	// 90 or 270 degree excitation
						echo_left <= (echoes_per_scan == '0) ? '0 :
							echoes_per_scan - seq_count_t'(1);
					end
				end
				ST_PULSE_90:
				begin
					if (phase_end)
					begin
						state <= ST_DELAY_90;
						timer <= last_tick(delay_r);
					end
				end
				ST_DELAY_90:
				begin
					if (phase_end)
					begin
						state    <= ST_PULSE_180;
						timer    <= last_tick(pulse_180_r);
						rf_phase <= 1'b1;	// 180 pulses always open high
					end
				end
				ST_PULSE_180:
				begin
					if (phase_end)
					begin
						state <= ST_DELAY_ECHO;
						timer <= last_tick(delay_r);
					end
				end
				ST_DELAY_ECHO:
				begin
					if (phase_end)
					begin
						state <= ST_ACQUIRE;
						timer <= last_tick(seq_time_t'(samples_r));
					end
				end
				ST_ACQUIRE:
				begin
					if (phase_end)
					begin
						if (echo_left == '0)
							state <= ST_IDLE;	// scan done, busy drops next cycle
						else
						begin
							echo_left <= echo_left - seq_count_t'(1);
							state     <= ST_PULSE_180;
							timer     <= last_tick(pulse_180_r);
							rf_phase  <= 1'b1;
						end
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// ======================================================================
	// outputs
	// ======================================================================

	assign busy       = (state != ST_IDLE);
	assign acq_window = (state == ST_ACQUIRE);	// doubles as receiver enable
	assign rf_out_p   = in_pulse & rf_phase;	// differential gate, quiet between pulses
	assign rf_out_n   = in_pulse & ~rf_phase;
	// shutdown outside pulses, unless masked off
	assign tx_out     = tx_en & ~(tx_sd_mask & ~in_pulse);

endmodule

`default_nettype wire

// File: design/echo_downconverter.sv
// adc capture aligned to the window latency, dc removal and fs/4 mixing into buffer entries
`timescale 1ns/100ps
`default_nettype none

module echo_downconverter #(
	parameter int ADC_LATENCY = 5		// window cycle to adc sample, cycles
) (
	input  wire                          pulseprog_clk,
	input  wire                          arst_n,
	input  wire                          acq_window,
	input  wire                          scan_start,
	input  wire nmr_data_pkg::adc_word_t adc_data,
	input  wire nmr_data_pkg::iq_val_t   adc_dc_val,
	output logic                         wr_en,
	output nmr_data_pkg::iq_entry_t      wr_entry,
	output logic                         adc_overrange
);
	import nmr_data_pkg::*;

	logic [ADC_LATENCY-1:0] win_sr;		// window flags in flight
	logic [ADC_LATENCY-1:0] first_sr;	// marks the first window cycle of a scan
	logic                   first_pend;	// scan started, first window not seen yet
	logic [1:0]             mix_ph;		// quarter-rate phase of the next capture
	logic [1:0]             cur_ph;
	logic                   capture;
	iq_val_t                s_val;		// dc-free sample
	iq_val_t                s_neg;

	assign capture = win_sr[ADC_LATENCY-1];
	assign cur_ph  = first_sr[ADC_LATENCY-1] ? 2'd0 : mix_ph;	// k restarts per scan
	assign s_val   = iq_val_t'({1'b0, adc_data[ADC_PHYS_WIDTH-1:0]}) - adc_dc_val;
	assign s_neg   = -s_val;

	always_ff @(posedge pulseprog_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			win_sr        <= '0;
			first_sr      <= '0;
			first_pend    <= 1'b0;
			mix_ph        <= 2'd0;
			wr_en         <= 1'b0;
			adc_overrange <= 1'b0;
		end
		else
		begin
			// trailing captures of the last scan can still be in the pipe here
			win_sr[0]   <= acq_window;
			first_sr[0] <= acq_window & first_pend;
			for (int j = 1; j < ADC_LATENCY; j++)
			begin
				win_sr[j]   <= win_sr[j-1];
				first_sr[j] <= first_sr[j-1];
			end
			first_pend <= scan_start | (first_pend & ~acq_window);
			wr_en      <= capture;	// written one cycle after capture
			if (capture)
				mix_ph <= cur_ph + 2'd1;
			if (capture & adc_data[ADC_PHYS_WIDTH])
				adc_overrange <= 1'b1;	// sticky for the scan
			else if (scan_start)
				adc_overrange <= 1'b0;
		end
	end

	// ======================================================================
	// mixer, cos/sin at fs/4 reduce to 1, 0, -1, 0
	// ======================================================================

	always_ff @(posedge pulseprog_clk)
	begin
		if (capture)
		begin
			wr_entry.first <= first_sr[ADC_LATENCY-1];
			case (cur_ph)
				2'd0:
				begin
					wr_entry.i <= s_val;
					wr_entry.q <= '0;
				end
				2'd1:
				begin
					wr_entry.i <= '0;
					wr_entry.q <= s_val;
				end
				2'd2:
				begin
					wr_entry.i <= s_neg;
					wr_entry.q <= '0;
				end
				default:
				begin
					wr_entry.i <= '0;
					wr_entry.q <= s_neg;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/iq_sample_fifo.sv
// circular buffer between the downconverter and the decimator, drops on full with sticky flag
`timescale 1ns/100ps
`default_nettype none

module iq_sample_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  wire                          pulseprog_clk,
	input  wire                          arst_n,
	input  wire                          wr_en,
	input  wire nmr_data_pkg::iq_entry_t wr_entry,
	input  wire                          rd_en,
	output nmr_data_pkg::iq_entry_t      rd_entry,
	output logic                         rd_valid,
	output logic                         fifo_overflow
);
	import nmr_data_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	iq_entry_t        mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;		// entries held
	logic             full;
	logic             push;
	logic             pop;

	// wraps at any depth, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + PTR_W'(1);
	endfunction

	assign full     = (fill == CNT_W'(FIFO_DEPTH));
	assign push     = wr_en & ~full;	// writer has no back-pressure
	assign pop      = rd_en & rd_valid;
	assign rd_valid = (fill != '0);	// one cycle after the write
	assign rd_entry = mem[rd_ptr];	// show-ahead read

	always_ff @(posedge pulseprog_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			fill          <= '0;
			fifo_overflow <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (push & ~pop)
				fill <= fill + CNT_W'(1);
			else if (pop & ~push)
				fill <= fill - CNT_W'(1);
			if (wr_en & full)
				fifo_overflow <= 1'b1;	// lost sample, held until reset
		end
	end

	always_ff @(posedge pulseprog_clk)
	begin
		if (push)
			mem[wr_ptr] <= wr_entry;
	end

endmodule

`default_nettype wire

// File: design/iq_decimator.sv
// keeps every n-th buffer entry and presents it as a held i/q word on the valid/ready output
`timescale 1ns/100ps
`default_nettype none

module iq_decimator (
	input  wire                                pulseprog_clk,
	input  wire                                arst_n,
	input  wire nmr_data_pkg::iq_entry_t       rd_entry,
	input  wire                                rd_valid,
	input  wire [nmr_data_pkg::DEC_WIDTH-1:0]  dec_fact,
	input  wire                                iq_ready,
	output logic                               rd_en,
	output logic                               iq_valid,
	output nmr_data_pkg::iq_out_t              iq_data
);
	import nmr_data_pkg::*;

	logic [DEC_WIDTH-1:0] dec_eff;	// zero behaves as one
	logic [DEC_WIDTH-1:0] cnt;		// index of the next entry within its group
	logic [DEC_WIDTH-1:0] idx;
	logic [DEC_WIDTH-1:0] idx_inc;
	logic                 keep;
	logic                 take;		// kept entry popped this cycle

	assign dec_eff = (dec_fact == '0) ? DEC_WIDTH'(1) : dec_fact;
	assign idx     = rd_entry.first ? '0 : cnt;	// count restarts on each scan
	assign idx_inc = idx + DEC_WIDTH'(1);
	assign keep    = (idx == '0);

	// discards drain freely, a kept entry waits for room in the output register
	assign rd_en = rd_valid & (~keep | ~iq_valid | iq_ready);
	assign take  = rd_en & keep;

	always_ff @(posedge pulseprog_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt      <= '0;
			iq_valid <= 1'b0;
		end
		else
		begin
			if (rd_en)
				cnt <= (idx_inc >= dec_eff) ? '0 : idx_inc;	// >= covers a factor lowered mid-run
			if (take)
				iq_valid <= 1'b1;
			else if (iq_ready)
				iq_valid <= 1'b0;	// word transferred
		end
	end

	// output word, stable while stalled
	always_ff @(posedge pulseprog_clk)
	begin
		if (take)
		begin
			iq_data.i <= 16'(iq_val_t'(rd_entry.i));	// signed cast, sign-extends
			iq_data.q <= 16'(iq_val_t'(rd_entry.q));
		end
	end

endmodule

`default_nettype wire

// File: design/nmr_pulse_programmer.sv
// pulse programmer top, wires the sequencer, downconverter, sample buffer and decimator together
`timescale 1ns/100ps
`default_nettype none

module nmr_pulse_programmer #(
	parameter int ADC_LATENCY = 5,		// see adc datasheet pipeline delay
	parameter int FIFO_DEPTH  = 16
) (
	input  wire                               pulseprog_clk,
	input  wire                               arst_n,
	// sequence control and parameters
	input  wire                               start,
	input  wire                               phase_cycle,
	input  wire nmr_seq_pkg::seq_time_t       pulse_90,
	input  wire nmr_seq_pkg::seq_time_t       pulse_180,
	input  wire nmr_seq_pkg::seq_time_t       delay_nosig,
	input  wire nmr_seq_pkg::seq_count_t      samples_per_echo,
	input  wire nmr_seq_pkg::seq_count_t      echoes_per_scan,
	input  wire                               tx_en,
	input  wire                               tx_sd_mask,
	output wire                               busy,
	// rf front end
	output wire                               rf_out_p,
	output wire                               rf_out_n,
	output wire                               tx_out,
	output wire                               rx_en,
	// adc and receive path
	input  wire nmr_data_pkg::adc_word_t      adc_data,
	input  wire nmr_data_pkg::iq_val_t        adc_dc_val,
	input  wire [nmr_data_pkg::DEC_WIDTH-1:0] dec_fact,
	output wire                               adc_overrange,
	output wire                               fifo_overflow,
	// i/q stream out
	output wire                               iq_valid,
	input  wire                               iq_ready,
	output wire nmr_data_pkg::iq_out_t        iq_data
);
	import nmr_data_pkg::*;

	logic      scan_start;	// first busy cycle
	logic      wr_en;
	iq_entry_t wr_entry;
	iq_entry_t rd_entry;
	logic      rd_valid;
	logic      rd_en;

	// ======================================================================
	// producer side
	// ======================================================================

	cpmg_sequencer u_seq (
		.pulseprog_clk    (pulseprog_clk),
		.arst_n           (arst_n),
		.start            (start),
		.phase_cycle      (phase_cycle),
		.pulse_90         (pulse_90),
		.pulse_180        (pulse_180),
		.delay_nosig      (delay_nosig),
		.samples_per_echo (samples_per_echo),
		.echoes_per_scan  (echoes_per_scan),
		.tx_en            (tx_en),
		.tx_sd_mask       (tx_sd_mask),
		.busy             (busy),
		.scan_start       (scan_start),
		.acq_window       (rx_en),		// window drives the receiver enable
		.rf_out_p         (rf_out_p),
		.rf_out_n         (rf_out_n),
		.tx_out           (tx_out)
	);

	echo_downconverter #(
		.ADC_LATENCY (ADC_LATENCY)
	) u_dconv (
		.pulseprog_clk (pulseprog_clk),
		.arst_n        (arst_n),
		.acq_window    (rx_en),
		.scan_start    (scan_start),
		.adc_data      (adc_data),
		.adc_dc_val    (adc_dc_val),
		.wr_en         (wr_en),
		.wr_entry      (wr_entry),
		.adc_overrange (adc_overrange)
	);

	// ======================================================================
	// buffer and consumer side
	// ======================================================================

	iq_sample_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.pulseprog_clk (pulseprog_clk),
		.arst_n        (arst_n),
		.wr_en         (wr_en),
		.wr_entry      (wr_entry),
		.rd_en         (rd_en),
		.rd_entry      (rd_entry),
		.rd_valid      (rd_valid),
		.fifo_overflow (fifo_overflow)
	);

	iq_decimator u_dec (
		.pulseprog_clk (pulseprog_clk),
		.arst_n        (arst_n),
		.rd_entry      (rd_entry),
		.rd_valid      (rd_valid),
		.dec_fact      (dec_fact),		// live, not latched per scan
		.iq_ready      (iq_ready),
		.rd_en         (rd_en),
		.iq_valid      (iq_valid),
		.iq_data       (iq_data)
	);

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
// testbench clock and reset source, 10 ns clock with reset held low for the first few cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
	parameter real PERIOD     = 10.0,	// ns
	parameter int  RST_CYCLES = 3
) (
	output logic pulseprog_clk,
	output logic arst_n
);

	initial
	begin
		pulseprog_clk = 1'b0;
		forever #(PERIOD / 2.0) pulseprog_clk = ~pulseprog_clk;
	end

	// release away from the rising edge
	initial
	begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge pulseprog_clk);
		@(negedge pulseprog_clk);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/tb_nmr_model.svh
// reference model of the scan timeline and receive path, included into the testbench top
`ifndef TB_NMR_MODEL_SVH
`define TB_NMR_MODEL_SVH

	logic [3:0] tl_q [$];	// per busy cycle: pulse, rx, rf_p, rf_n
	iq_out_t    exp_q [$];	// predicted output words, in order
	int         mix_k;		// capture index mod 4
	int         dec_cnt;	// entry index within decimation group
	seq_count_t exp_rx;
	seq_count_t exp_tx;
	seq_count_t exp_words;

	// zero lengths and counts run as one
	function automatic int eff(input int v);
		return (v == 0) ? 1 : v;
	endfunction

	// expected busy timeline and per-scan counts
	function automatic void build_timeline(input int p90, input int p180, input int dly,
		input int sp, input int ep, input int dec, input logic ph, input logic ten);
		int n_ent;
		tl_q.delete();
		for (int i = 0; i < eff(p90); i++)
			tl_q.push_back({2'b10, ph ^ i[0], ~(ph ^ i[0])});	// starts at phase_cycle
		for (int i = 0; i < eff(dly); i++)
			tl_q.push_back(4'b0000);
		for (int e = 0; e < eff(ep); e++)
		begin
			for (int i = 0; i < eff(p180); i++)
				tl_q.push_back({2'b10, ~i[0], i[0]});	// 180 opens high
			for (int i = 0; i < eff(dly); i++)
				tl_q.push_back(4'b0000);
			for (int i = 0; i < eff(sp); i++)
				tl_q.push_back(4'b0100);	// acquisition
		end
		n_ent     = eff(ep) * eff(sp);
		exp_rx    = seq_count_t'(n_ent);
		exp_tx    = ten ? seq_count_t'(eff(p90) + eff(ep) * eff(p180)) : '0;
		exp_words = seq_count_t'((n_ent + eff(dec) - 1) / eff(dec));
	endfunction

	// one aligned adc capture: dc removal, fs/4 mixing, decimation
	function automatic void model_capture(input adc_word_t adc, input iq_val_t dc,
		input logic first, input int dec);
		iq_val_t s;
		iq_val_t i_v;
		iq_val_t q_v;
		iq_out_t w;
		s = iq_val_t'({1'b0, adc[ADC_PHYS_WIDTH-1:0]}) - dc;
		if (first)
		begin
			mix_k   = 0;	// new scan
			dec_cnt = 0;
		end
		i_v = '0;
		q_v = '0;
		case (mix_k)
			0: i_v = s;
			1: q_v = s;
			2: i_v = -s;
			default: q_v = -s;
		endcase
		if (dec_cnt == 0)
		begin
			w.i = {i_v[ADC_PHYS_WIDTH], i_v};	// 15 to 16 bits
			w.q = {q_v[ADC_PHYS_WIDTH], q_v};
			exp_q.push_back(w);
		end
		dec_cnt = (dec_cnt + 1) % eff(dec);
		mix_k   = (mix_k + 1) % 4;
	endfunction

	task automatic check_word(input string name, input iq_out_t got, input iq_out_t exp);
		if (got !== exp)
			raise_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(input string name, input seq_count_t got, input seq_count_t exp);
		if (got !== exp)
			raise_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			raise_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

`endif

// File: dv/tb_nmr_pulse_programmer.sv
// testbench top that runs random cpmg scans through the pulse programmer against a model
`timescale 1ns/100ps
`default_nettype none

module tb_nmr_pulse_programmer;
	import nmr_seq_pkg::*;
	import nmr_data_pkg::*;

	localparam int ADC_LATENCY = 5;
	localparam int FIFO_DEPTH  = 16;
	localparam int TIMEOUT     = 2000;	// cycles per wait

	logic                 pulseprog_clk;
	logic                 arst_n;
	logic                 start;
	logic                 phase_cycle;
	seq_time_t            pulse_90;
	seq_time_t            pulse_180;
	seq_time_t            delay_nosig;
	seq_count_t           samples_per_echo;
	seq_count_t           echoes_per_scan;
	logic                 tx_en;
	logic                 tx_sd_mask;
	adc_word_t            adc_data;
	iq_val_t              adc_dc_val;
	logic [DEC_WIDTH-1:0] dec_fact;
	logic                 iq_ready;
	wire                  busy;
	wire                  rf_out_p;
	wire                  rf_out_n;
	wire                  tx_out;
	wire                  rx_en;
	wire                  adc_overrange;
	wire                  fifo_overflow;
	wire                  iq_valid;
	iq_out_t              iq_data;

	int         ready_mode;	// 0 random, 1 low, 2 high
	logic       or_force;	// over-range bit on captured adc words
	logic       hist_rx [ADC_LATENCY];
	logic       hist_first [ADC_LATENCY];
	logic       seen;		// window seen in this scan
	logic       started;
	seq_count_t rx_cnt;
	seq_count_t txp_cnt;
	seq_count_t words_rx;

	tb_clk_gen #(
		.PERIOD     (10.0),
		.RST_CYCLES (3)
	) u_clk (
		.pulseprog_clk (pulseprog_clk),
		.arst_n        (arst_n)
	);

	nmr_pulse_programmer #(
		.ADC_LATENCY (ADC_LATENCY),
		.FIFO_DEPTH  (FIFO_DEPTH)
	) u_dut (.*);

	task automatic raise_error(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

`include "tb_nmr_model.svh"

	// ======================================================================
	// free-running stimulus
	// ======================================================================

	always @(posedge pulseprog_clk)
	begin
		case (ready_mode)
			0: iq_ready <= ($urandom_range(3) != 0);	// about 75% high
			1: iq_ready <= 1'b0;
			default: iq_ready <= 1'b1;
		endcase
	end

	// ======================================================================
	// monitor and adc stimulus on pre-edge values
	// ======================================================================

	always @(posedge pulseprog_clk)
	begin
		if (arst_n)
		begin
			if (hist_rx[ADC_LATENCY-1])
				model_capture(adc_data, adc_dc_val, hist_first[ADC_LATENCY-1], int'(dec_fact));
			for (int j = ADC_LATENCY - 1; j > 0; j--)
			begin
				hist_rx[j]    = hist_rx[j-1];
				hist_first[j] = hist_first[j-1];
			end
			hist_rx[0]    = rx_en;
			hist_first[0] = rx_en & ~seen;
			if (rx_en)
				seen = 1'b1;
			else if (!busy)
				seen = 1'b0;
			// word for the coming cycle, captured at the next edge when the flag reached the end
			if (hist_rx[ADC_LATENCY-1])
				adc_data <= {or_force, 14'($urandom)};
			else
				adc_data <= {1'($urandom), 14'($urandom)};	// stray over-range bits
			// output stream against the head of the model queue
			if (iq_valid)
			begin
				if (exp_q.size() == 0)
					raise_error("output word arrived that the model does not predict");
				check_word("iq_data", iq_data, exp_q[0]);	// also holds it steady while stalled
				if (iq_ready)
				begin
					void'(exp_q.pop_front());
					words_rx++;
				end
			end
			// sequencer outputs against the timeline
			if (busy)
			begin
				logic [3:0] e;
				started = 1'b1;
				if (tl_q.size() == 0)
					raise_error("busy stayed high past the end of the scan");
				e = tl_q.pop_front();
				check_flag("rx_en", rx_en, e[2]);
				check_flag("rf_out_p", rf_out_p, e[1]);
				check_flag("rf_out_n", rf_out_n, e[0]);
				check_flag("tx_out", tx_out, tx_en & (e[3] | ~tx_sd_mask));
				if (rx_en)
					rx_cnt++;
				if (e[3] & tx_out)
					txp_cnt++;
			end
			else
			begin
				if (started && tl_q.size() != 0)
					raise_error("busy fell before the scan was complete");
				started = 1'b0;
				check_flag("rx_en", rx_en, 1'b0);
				check_flag("rf_out_p", rf_out_p, 1'b0);
				check_flag("rf_out_n", rf_out_n, 1'b0);
				check_flag("tx_out", tx_out, tx_en & ~tx_sd_mask);
			end
		end
	end

	// ======================================================================
	// waits and scan driver
	// ======================================================================

	task automatic wait_busy(input logic level);
		int n;
		n = 0;
		while (busy !== level && n < TIMEOUT)
		begin
			@(posedge pulseprog_clk);
			n++;
		end
		if (busy !== level)
			raise_error($sformatf("timed out waiting for busy to go %0d", level));
	endtask

	task automatic wait_drained(input int words);
		int n;
		n = 0;
		while (int'(words_rx) < words && n < TIMEOUT)
		begin
			@(posedge pulseprog_clk);
			n++;
		end
		if (int'(words_rx) < words)
			raise_error("timed out waiting for output words");
	endtask

	task automatic run_scan(input int p90, input int p180, input int dly, input int sp,
		input int ep, input int dec, input logic or_on, input logic ovf_test);
		logic ph;
		logic ten;
		logic msk;
		ph  = 1'($urandom);
		ten = ($urandom_range(3) != 0);
		msk = 1'($urandom);
		@(negedge pulseprog_clk);
		ready_mode = ovf_test ? 1 : 0;
		or_force   = or_on;
		@(posedge pulseprog_clk);
		build_timeline(p90, p180, dly, sp, ep, dec, ph, ten);
		rx_cnt           = '0;
		txp_cnt          = '0;
		words_rx         = '0;
		dec_fact         <= DEC_WIDTH'(dec);
		adc_dc_val       <= iq_val_t'($urandom);
		pulse_90         <= seq_time_t'(p90);
		pulse_180        <= seq_time_t'(p180);
		delay_nosig      <= seq_time_t'(dly);
		samples_per_echo <= seq_count_t'(sp);
		echoes_per_scan  <= seq_count_t'(ep);
		phase_cycle      <= ph;
		tx_en            <= ten;
		tx_sd_mask       <= msk;
		start            <= 1'b1;
		@(posedge pulseprog_clk);
		start <= 1'b0;
		wait_busy(1'b1);
		// second start lands mid-scan and must be ignored
		@(posedge pulseprog_clk);
		check_flag("adc_overrange", adc_overrange, 1'b0);	// cleared by the start
		start            <= 1'b1;
		phase_cycle      <= ~ph;
		pulse_90         <= seq_time_t'($urandom_range(9));
		pulse_180        <= seq_time_t'($urandom_range(9));
		delay_nosig      <= seq_time_t'($urandom_range(9));
		samples_per_echo <= seq_count_t'($urandom_range(9));
		echoes_per_scan  <= seq_count_t'($urandom_range(9));
		@(posedge pulseprog_clk);
		start <= 1'b0;
		wait_busy(1'b0);
		repeat (ADC_LATENCY + 2) @(posedge pulseprog_clk);	// last captures written
		check_count("rx_en cycles", rx_cnt, exp_rx);
		check_count("tx_out pulse cycles", txp_cnt, exp_tx);
		check_flag("adc_overrange", adc_overrange, or_on);
		check_flag("fifo_overflow", fifo_overflow, ovf_test);
		if (ovf_test)
		begin
			@(negedge pulseprog_clk);
			ready_mode = 2;
			wait_drained(FIFO_DEPTH + 1);	// full buffer plus the output register
			repeat (20) @(posedge pulseprog_clk);
			check_count("words after overflow", words_rx, seq_count_t'(FIFO_DEPTH + 1));
			check_flag("iq_valid", iq_valid, 1'b0);
			exp_q.delete();	// dropped entries never come out
		end
		else
		begin
			wait_drained(int'(exp_words));
			repeat (4) @(posedge pulseprog_clk);
			check_count("words per scan", words_rx, exp_words);
		end
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================

	initial
	begin
		int n;
		void'($urandom(32'hcb8c_e9f1));
		ready_mode       = 2;
		or_force         = 1'b0;
		seen             = 1'b0;
		started          = 1'b0;
		mix_k            = 0;
		dec_cnt          = 0;
		rx_cnt           = '0;
		txp_cnt          = '0;
		words_rx         = '0;
		start            = 1'b0;
		phase_cycle      = 1'b0;
		pulse_90         = '0;
		pulse_180        = '0;
		delay_nosig      = '0;
		samples_per_echo = '0;
		echoes_per_scan  = '0;
		tx_en            = 1'b0;
		tx_sd_mask       = 1'b0;
		adc_data         = '0;
		adc_dc_val       = '0;
		dec_fact         = '0;
		iq_ready         = 1'b1;
		for (int j = 0; j < ADC_LATENCY; j++)
		begin
			hist_rx[j]    = 1'b0;
			hist_first[j] = 1'b0;
		end
		n = 0;
		while (!arst_n && n < TIMEOUT)
		begin
			@(posedge pulseprog_clk);
			n++;
		end
		if (!arst_n)
			raise_error("reset never released");
		@(posedge pulseprog_clk);
		check_flag("busy", busy, 1'b0);
		check_flag("iq_valid", iq_valid, 1'b0);
		check_flag("adc_overrange", adc_overrange, 1'b0);
		check_flag("fifo_overflow", fifo_overflow, 1'b0);
		for (int s = 0; s < 14; s++)
			run_scan($urandom_range(6), $urandom_range(6), $urandom_range(6),
				$urandom_range(12), $urandom_range(4), $urandom_range(4), 1'b0, 1'b0);
		run_scan(2, 3, 1, 9, 3, 0, 1'b0, 1'b0);		// factor zero keeps all
		run_scan(1, 2, 2, 7, 2, 3, 1'b1, 1'b0);		// over-range words
		run_scan(3, 1, 2, 5, 2, 2, 1'b0, 1'b0);		// start clears the flag
		run_scan(2, 2, 1, 30, 2, 1, 1'b0, 1'b1);	// stalled sink
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+dv
design/nmr_seq_pkg.sv
design/nmr_data_pkg.sv
design/cpmg_sequencer.sv
design/echo_downconverter.sv
design/iq_sample_fifo.sv
design/iq_decimator.sv
design/nmr_pulse_programmer.sv
dv/tb_clk_gen.sv
dv/tb_nmr_pulse_programmer.sv

// File: Bender.yml
package:
  name: nmr_pulse_programmer

sources:
  - files:
      - design/nmr_seq_pkg.sv
      - design/nmr_data_pkg.sv
      - design/cpmg_sequencer.sv
      - design/echo_downconverter.sv
      - design/iq_sample_fifo.sv
      - design/iq_decimator.sv
      - design/nmr_pulse_programmer.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_nmr_pulse_programmer.sv
